/* hw/net_hdr_pkg.sv */
`default_nettype none

package net_hdr_pkg;

  localparam int MAC_W  = 48;
  localparam int IP_W   = 32;
  localparam int PORT_W = 16;
  localparam int HOST_W = 8;

  // One address word, seen whole or as subnet and host
  typedef union packed {
    logic [IP_W-1:0] word;
    struct packed {
      logic [IP_W-HOST_W-1:0] subnet;
      logic [HOST_W-1:0]      host;
    } part;
  } ip_addr_u;

  // IP plus UDP header bytes on top of the payload
  localparam logic [15:0] IP_HDR_OVERHEAD  = 16'd28;
  localparam logic [15:0] UDP_HDR_OVERHEAD = 16'd8;

  // Version, ID, flags, TTL and protocol halfwords already summed
  localparam logic [15:0] CSUM_SEED = 16'h8412;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_VER_IHL     = 8'h45;
  localparam logic [7:0]  IP_FLAGS       = 8'h40;
  localparam logic [7:0]  IP_TTL         = 8'hFF;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'h11;

endpackage

`default_nettype wire

/* hw/tx_path_pkg.sv */
`default_nettype none

package tx_path_pkg;

  localparam int WORD_W = 64;
  localparam int LEN_W  = 16;
  localparam int KEEP_W = 8;

  // Words before the first payload word
  localparam logic [LEN_W-1:0] HDR_WORDS = 16'd5;

  // Byte-valid codes on the MAC side
  localparam logic [KEEP_W-1:0] KEEP_ALL  = 8'hFF;
  localparam logic [KEEP_W-1:0] KEEP_TAIL = 8'h03;
  localparam logic [KEEP_W-1:0] KEEP_NONE = 8'h00;

endpackage

`default_nettype wire

/* hw/frame_desc_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface frame_desc_if;

  logic [tx_path_pkg::WORD_W-1:0] data;
  logic                           data_rd;
  net_hdr_pkg::ip_addr_u          dest_ip;
  logic [net_hdr_pkg::PORT_W-1:0] dest_port;
  logic [tx_path_pkg::LEN_W-1:0]  size_words;
  logic                           desc_empty;
  logic                           desc_rd;

  modport queue (output data, dest_ip, dest_port, size_words, desc_empty,
                 input data_rd, desc_rd);

  modport framer (input data, dest_ip, dest_port, size_words, desc_empty,
                  output data_rd, desc_rd);

  // Header arithmetic only watches the head descriptor
  modport calc (input dest_ip, size_words);

endinterface

`default_nettype wire

/* hw/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH        = 64,
  parameter int DEPTH        = 1024,
  parameter int AFULL_MARGIN = 8
) (
  input  logic             mac_clk,
  input  logic             app_rst,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] din,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             afull,
  output logic             overflow
);

  // Pointers wrap naturally at a power-of-two depth
  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] FULL_LVL  = (AW+1)'(DEPTH);
  localparam logic [AW:0] AFULL_LVL = (AW+1)'(DEPTH - AFULL_MARGIN);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;
  logic             full;
  logic             do_wr;
  logic             do_rd;

  assign full  = (count == FULL_LVL);
  assign empty = (count == '0);
  assign afull = (count >= AFULL_LVL);
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // Show-ahead head word
  assign dout = mem[rd_ptr];

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // Write into a full buffer is dropped
      overflow <= wr_en && full;
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_underflow: assert property (@(posedge mac_clk) disable iff (app_rst)
    rd_en |-> !empty);

endmodule

`default_nettype wire

/* hw/tx_frame_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_frame_queue #(
  parameter int DATA_DEPTH   = 1024,
  parameter int CTRL_DEPTH   = 64,
  parameter int AFULL_MARGIN = 8
) (
  input  logic                           mac_clk,
  input  logic                           app_rst,
  input  logic                           app_tx_valid,
  input  logic                           app_tx_end_of_frame,
  input  logic [tx_path_pkg::WORD_W-1:0] app_tx_data,
  input  logic [net_hdr_pkg::IP_W-1:0]   app_tx_dest_ip,
  input  logic [net_hdr_pkg::PORT_W-1:0] app_tx_dest_port,
  output logic                           app_tx_afull,
  output logic                           app_tx_overflow,
  frame_desc_if.queue                    q
);

  localparam int DESC_W = tx_path_pkg::LEN_W + net_hdr_pkg::PORT_W + net_hdr_pkg::IP_W;

  logic [tx_path_pkg::LEN_W-1:0] word_count;
  logic [DESC_W-1:0]             desc_dout;
  logic                          desc_push;
  logic                          data_empty;
  logic                          data_afull;
  logic                          desc_afull;
  logic                          data_ovf;
  logic                          desc_ovf;

  assign desc_push = app_tx_valid && app_tx_end_of_frame;

  // Starts at one so the closing word is already counted
  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      word_count <= 16'd1;
    end else if (desc_push) begin
      word_count <= 16'd1;
    end else if (app_tx_valid) begin
      word_count <= word_count + 1'b1;
    end
  end

  sync_fifo #(
    .WIDTH        (tx_path_pkg::WORD_W),
    .DEPTH        (DATA_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) u_data_fifo (
    .mac_clk  (mac_clk),
    .app_rst  (app_rst),
    .wr_en    (app_tx_valid),
    .din      (app_tx_data),
    .rd_en    (q.data_rd),
    .dout     (q.data),
    .empty    (data_empty),
    .afull    (data_afull),
    .overflow (data_ovf)
  );

  sync_fifo #(
    .WIDTH        (DESC_W),
    .DEPTH        (CTRL_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) u_desc_fifo (
    .mac_clk  (mac_clk),
    .app_rst  (app_rst),
    .wr_en    (desc_push),
    .din      ({word_count, app_tx_dest_port, app_tx_dest_ip}),
    .rd_en    (q.desc_rd),
    .dout     (desc_dout),
    .empty    (q.desc_empty),
    .afull    (desc_afull),
    .overflow (desc_ovf)
  );

  assign q.size_words = desc_dout[DESC_W-1 -: tx_path_pkg::LEN_W];
  assign q.dest_port  = desc_dout[net_hdr_pkg::IP_W +: net_hdr_pkg::PORT_W];
  assign q.dest_ip    = desc_dout[net_hdr_pkg::IP_W-1:0];

  assign app_tx_afull = data_afull || desc_afull;

  // Sticky until reset
  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      app_tx_overflow <= 1'b0;
    end else if (data_ovf || desc_ovf) begin
      app_tx_overflow <= 1'b1;
    end
  end

  // A head descriptor always has its payload queued behind it
  a_desc_has_data: assert property (@(posedge mac_clk) disable iff (app_rst)
    (!q.desc_empty && !q.desc_rd) |-> !data_empty);

endmodule

`default_nettype wire

/* hw/arp_table.sv */
`timescale 1ns/1ps
`default_nettype none

module arp_table (
  input  logic                           mac_clk,
  input  logic                           arp_wr_en,
  input  logic [net_hdr_pkg::HOST_W-1:0] arp_wr_addr,
  input  logic [net_hdr_pkg::MAC_W-1:0]  arp_wr_data,
  input  logic [net_hdr_pkg::HOST_W-1:0] arp_index,
  output logic [net_hdr_pkg::MAC_W-1:0]  dest_mac
);

  logic [net_hdr_pkg::MAC_W-1:0] mem [2**net_hdr_pkg::HOST_W];

  // Filled from outside before traffic starts
  always_ff @(posedge mac_clk) begin
    if (arp_wr_en) begin
      mem[arp_wr_addr] <= arp_wr_data;
    end
  end

  // One cycle lookup for the framer
  always_ff @(posedge mac_clk) begin
    dest_mac <= mem[arp_index];
  end

endmodule

`default_nettype wire

/* hw/udp_hdr_calc.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_hdr_calc (
  input  logic                           mac_clk,
  input  logic                           app_rst,
  input  logic [net_hdr_pkg::IP_W-1:0]   local_ip,
  input  logic [net_hdr_pkg::HOST_W-1:0] local_gateway,
  frame_desc_if.calc                     d,
  output logic [15:0]                    ip_length,
  output logic [15:0]                    udp_length,
  output logic [15:0]                    ip_checksum,
  output logic [net_hdr_pkg::HOST_W-1:0] arp_index
);

  net_hdr_pkg::ip_addr_u lip;
  logic [15:0]           fixed_sum;
  logic [17:0]           sum0;

  // Two end-around carry folds of an 18-bit partial sum
  function automatic logic [15:0] fold18(input logic [17:0] s);
    logic [16:0] s1;
    s1 = {1'b0, s[15:0]} + {15'b0, s[17:16]};
    return s1[15:0] + {15'b0, s1[16]};
  endfunction

  assign lip = local_ip;

  // Seed plus source address never changes during a frame
  assign fixed_sum = fold18({2'b00, net_hdr_pkg::CSUM_SEED} + {2'b00, lip.word[31:16]} +
                            {2'b00, lip.word[15:0]});

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      ip_length   <= '0;
      udp_length  <= '0;
      sum0        <= '0;
      ip_checksum <= '0;
    end else begin
      ip_length   <= (d.size_words << 3) + net_hdr_pkg::IP_HDR_OVERHEAD;
      udp_length  <= (d.size_words << 3) + net_hdr_pkg::UDP_HDR_OVERHEAD;
      sum0        <= {2'b00, fixed_sum} + {2'b00, ip_length} +
                     {2'b00, d.dest_ip.word[31:16]} + {2'b00, d.dest_ip.word[15:0]};
      ip_checksum <= ~fold18(sum0);
    end
  end

  // Off-subnet traffic goes to the gateway entry
  assign arp_index = (d.dest_ip.part.subnet != lip.part.subnet) ? local_gateway :
                     d.dest_ip.part.host;

endmodule

`default_nettype wire

/* hw/udp_tx_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_tx_framer (
  input  logic                           mac_clk,
  input  logic                           app_rst,
  input  logic                           local_enable,
  input  logic [net_hdr_pkg::MAC_W-1:0]  local_mac,
  input  logic [net_hdr_pkg::IP_W-1:0]   local_ip,
  input  logic [net_hdr_pkg::PORT_W-1:0] local_port,
  input  logic                           app_tx_overflow,
  frame_desc_if.framer                   f,
  input  logic [net_hdr_pkg::MAC_W-1:0]  dest_mac,
  input  logic [15:0]                    ip_length,
  input  logic [15:0]                    udp_length,
  input  logic [15:0]                    ip_checksum,
  input  logic                           mac_tx_ack,
  output logic                           mac_tx_start,
  output logic [tx_path_pkg::WORD_W-1:0] mac_tx_data,
  output logic [tx_path_pkg::KEEP_W-1:0] mac_tx_data_valid
);

  // Header states step by one
  localparam logic [3:0] ST_IDLE  = 4'd0;
  localparam logic [3:0] ST_HDR1  = 4'd1;
  localparam logic [3:0] ST_HDR2  = 4'd2;
  localparam logic [3:0] ST_HDR3  = 4'd3;
  localparam logic [3:0] ST_HDR4  = 4'd4;
  localparam logic [3:0] ST_HDR5  = 4'd5;
  localparam logic [3:0] ST_FIRST = 4'd6;
  localparam logic [3:0] ST_DATA  = 4'd7;
  localparam logic [3:0] ST_LAST  = 4'd8;

  logic [3:0]                    state;
  logic [tx_path_pkg::LEN_W-1:0] remain;
  logic [15:0]                   leftover;
  logic [2:0]                    head_age;

  function automatic logic [15:0] bswap16(input logic [15:0] x);
    return {x[7:0], x[15:8]};
  endfunction

  function automatic logic [31:0] bswap32(input logic [31:0] x);
    return {bswap16(x[15:0]), bswap16(x[31:16])};
  endfunction

  function automatic logic [47:0] bswap48(input logic [47:0] x);
    return {bswap16(x[15:0]), bswap16(x[31:16]), bswap16(x[47:32])};
  endfunction

  assign mac_tx_start = (state == ST_IDLE) && !f.desc_empty && local_enable && !app_tx_overflow;
  assign f.data_rd    = (state == ST_FIRST) || (state == ST_DATA);
  assign f.desc_rd    = (state == ST_LAST);

  // remain counts the words still due before the tail word
  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      state             <= ST_IDLE;
      remain            <= '0;
      mac_tx_data_valid <= tx_path_pkg::KEEP_NONE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (mac_tx_start) begin
            remain            <= tx_path_pkg::HDR_WORDS + f.size_words;
            mac_tx_data_valid <= tx_path_pkg::KEEP_ALL;
            state             <= ST_HDR1;
          end
        end
        ST_HDR1: begin
          if (mac_tx_ack) begin
            remain <= remain - 1'b1;
            state  <= ST_HDR2;
          end
        end
        ST_HDR2, ST_HDR3, ST_HDR4, ST_HDR5: begin
          remain <= remain - 1'b1;
          state  <= state + 1'b1;
        end
        ST_FIRST, ST_DATA: begin
          if (remain == 16'd1) begin
            mac_tx_data_valid <= tx_path_pkg::KEEP_TAIL;
            state             <= ST_LAST;
          end else begin
            remain <= remain - 1'b1;
            state  <= ST_DATA;
          end
        end
        ST_LAST: begin
          mac_tx_data_valid <= tx_path_pkg::KEEP_NONE;
          state             <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Low two bytes spill into the next MAC word
  always_ff @(posedge mac_clk) begin
    if (f.data_rd) begin
      leftover <= f.data[15:0];
    end
  end

  // Cycles since the current head descriptor appeared
  always_ff @(posedge mac_clk) begin
    if (app_rst || f.desc_empty || f.desc_rd) begin
      head_age <= '0;
    end else if (head_age != 3'd7) begin
      head_age <= head_age + 1'b1;
    end
  end

  // Lane 0 goes out first
  always_comb begin
    case (state)
      ST_HDR1:  mac_tx_data = {bswap16(local_mac[47:32]), bswap48(dest_mac)};
      ST_HDR2:  mac_tx_data = {8'h00, net_hdr_pkg::IP_VER_IHL,
                               bswap16(net_hdr_pkg::ETHERTYPE_IPV4), bswap32(local_mac[31:0])};
      ST_HDR3:  mac_tx_data = {net_hdr_pkg::IP_PROTO_UDP, net_hdr_pkg::IP_TTL, 8'h00,
                               net_hdr_pkg::IP_FLAGS, 16'h0000, bswap16(ip_length)};
      ST_HDR4:  mac_tx_data = {bswap16(f.dest_ip.word[31:16]), bswap32(local_ip),
                               bswap16(ip_checksum)};
      ST_HDR5:  mac_tx_data = {bswap16(udp_length), bswap16(f.dest_port),
                               bswap16(local_port), bswap16(f.dest_ip.word[15:0])};
      // UDP checksum left at zero
      ST_FIRST: mac_tx_data = {bswap48(f.data[63:16]), 16'h0000};
      ST_DATA:  mac_tx_data = {bswap48(f.data[63:16]), bswap16(leftover)};
      ST_LAST:  mac_tx_data = {48'h0, bswap16(leftover)};
      default:  mac_tx_data = '0;
    endcase
  end

  // Legal byte-valid code for every state
  a_keep_legal: assert property (@(posedge mac_clk) disable iff (app_rst)
    mac_tx_data_valid == ((state == ST_IDLE) ? tx_path_pkg::KEEP_NONE :
                          (state == ST_LAST) ? tx_path_pkg::KEEP_TAIL :
                          tx_path_pkg::KEEP_ALL));

  // Checksum needs three cycles after a new head
  a_csum_settled: assert property (@(posedge mac_clk) disable iff (app_rst)
    (state == ST_HDR4) |-> (head_age >= 3'd4));

endmodule

`default_nettype wire

/* hw/udp_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_tx_top #(
  parameter int DATA_DEPTH   = 1024,
  parameter int CTRL_DEPTH   = 64,
  parameter int AFULL_MARGIN = 8
) (
  input  logic                           mac_clk,
  input  logic                           app_rst,
  input  logic                           local_enable,
  input  logic [net_hdr_pkg::MAC_W-1:0]  local_mac,
  input  logic [net_hdr_pkg::IP_W-1:0]   local_ip,
  input  logic [net_hdr_pkg::PORT_W-1:0] local_port,
  input  logic [net_hdr_pkg::HOST_W-1:0] local_gateway,
  input  logic                           arp_wr_en,
  input  logic [net_hdr_pkg::HOST_W-1:0] arp_wr_addr,
  input  logic [net_hdr_pkg::MAC_W-1:0]  arp_wr_data,
  input  logic                           app_tx_valid,
  input  logic                           app_tx_end_of_frame,
  input  logic [tx_path_pkg::WORD_W-1:0] app_tx_data,
  input  logic [net_hdr_pkg::IP_W-1:0]   app_tx_dest_ip,
  input  logic [net_hdr_pkg::PORT_W-1:0] app_tx_dest_port,
  output logic                           app_tx_afull,
  output logic                           app_tx_overflow,
  output logic [tx_path_pkg::WORD_W-1:0] mac_tx_data,
  output logic [tx_path_pkg::KEEP_W-1:0] mac_tx_data_valid,
  output logic                           mac_tx_start,
  input  logic                           mac_tx_ack
);

  logic [15:0]                    ip_length;
  logic [15:0]                    udp_length;
  logic [15:0]                    ip_checksum;
  logic [net_hdr_pkg::HOST_W-1:0] arp_index;
  logic [net_hdr_pkg::MAC_W-1:0]  dest_mac;

  frame_desc_if fd ();

  tx_frame_queue #(
    .DATA_DEPTH   (DATA_DEPTH),
    .CTRL_DEPTH   (CTRL_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) u_queue (
    .mac_clk             (mac_clk),
    .app_rst             (app_rst),
    .app_tx_valid        (app_tx_valid),
    .app_tx_end_of_frame (app_tx_end_of_frame),
    .app_tx_data         (app_tx_data),
    .app_tx_dest_ip      (app_tx_dest_ip),
    .app_tx_dest_port    (app_tx_dest_port),
    .app_tx_afull        (app_tx_afull),
    .app_tx_overflow     (app_tx_overflow),
    .q                   (fd)
  );

  arp_table u_arp (
    .mac_clk     (mac_clk),
    .arp_wr_en   (arp_wr_en),
    .arp_wr_addr (arp_wr_addr),
    .arp_wr_data (arp_wr_data),
    .arp_index   (arp_index),
    .dest_mac    (dest_mac)
  );

  udp_hdr_calc u_calc (
    .mac_clk       (mac_clk),
    .app_rst       (app_rst),
    .local_ip      (local_ip),
    .local_gateway (local_gateway),
    .d             (fd),
    .ip_length     (ip_length),
    .udp_length    (udp_length),
    .ip_checksum   (ip_checksum),
    .arp_index     (arp_index)
  );

  udp_tx_framer u_framer (
    .mac_clk           (mac_clk),
    .app_rst           (app_rst),
    .local_enable      (local_enable),
    .local_mac         (local_mac),
    .local_ip          (local_ip),
    .local_port        (local_port),
    .app_tx_overflow   (app_tx_overflow),
    .f                 (fd),
    .dest_mac          (dest_mac),
    .ip_length         (ip_length),
    .udp_length        (udp_length),
    .ip_checksum       (ip_checksum),
    .mac_tx_ack        (mac_tx_ack),
    .mac_tx_start      (mac_tx_start),
    .mac_tx_data       (mac_tx_data),
    .mac_tx_data_valid (mac_tx_data_valid)
  );

endmodule

`default_nettype wire

/* dv/tb_frame_model.svh */
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

logic [31:0] lfsr_state = 32'd71890;
logic [7:0]  exp_bytes [$];

// Taps 32, 22, 2, 1
function automatic logic lfsr_next_bit();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

function automatic logic [63:0] lfsr_take(input int nbits);
  logic [63:0] v;
  v = '0;
  for (int i = 0; i < nbits; i++) begin
    v = {v[62:0], lfsr_next_bit()};
  end
  return v;
endfunction

// Distinct MAC per table index
function automatic logic [47:0] arp_fill(input logic [7:0] idx);
  return {8'h02, 8'h5E, idx, ~idx, idx ^ 8'hC3, {idx[3:0], idx[7:4]}};
endfunction

function automatic void push16(input logic [15:0] v);
  exp_bytes.push_back(v[15:8]);
  exp_bytes.push_back(v[7:0]);
endfunction

function automatic void push48(input logic [47:0] v);
  push16(v[47:32]);
  push16(v[31:16]);
  push16(v[15:0]);
endfunction

function automatic void push64(input logic [63:0] v);
  push16(v[63:48]);
  push48(v[47:0]);
endfunction

// Ethernet, IP and UDP header bytes in wire order
function automatic void model_header(input logic [47:0] dmac, input logic [31:0] dip,
                                     input logic [15:0] dport, input int nwords);
  logic [15:0] ip_len;
  logic [15:0] udp_len;
  logic [31:0] acc;
  logic [15:0] hw [10];
  ip_len  = 16'(nwords * 8 + 28);
  udp_len = 16'(nwords * 8 + 8);
  hw = '{16'h4500, ip_len, 16'h0000, 16'h4000, 16'hFF11, 16'h0000,
         local_ip[31:16], local_ip[15:0], dip[31:16], dip[15:0]};
  acc = '0;
  for (int i = 0; i < 10; i++) begin
    acc = acc + {16'h0000, hw[i]};
  end
  while (acc[31:16] != 16'h0000) begin
    acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
  end
  push48(dmac);
  push48(local_mac);
  push16(16'h0800);
  for (int i = 0; i < 5; i++) begin
    push16(hw[i]);
  end
  push16(~acc[15:0]);
  push16(local_ip[31:16]);
  push16(local_ip[15:0]);
  push16(dip[31:16]);
  push16(dip[15:0]);
  push16(local_port);
  push16(dport);
  push16(udp_len);
  // UDP checksum not used
  push16(16'h0000);
endfunction

`endif

/* dv/tb_udp_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_udp_tx;

  localparam int CTRL_DEPTH   = 64;
  localparam int AFULL_MARGIN = 8;
  localparam int NROWS        = 9;

  typedef struct packed {
    int          nwords;
    logic [31:0] dip;
    logic [15:0] dport;
    logic        en;
    int          ack;
  } frame_row_t;

  logic        mac_clk = 1'b0;
  logic        app_rst;
  logic        local_enable;
  logic [47:0] local_mac;
  logic [31:0] local_ip;
  logic [15:0] local_port;
  logic [7:0]  local_gateway;
  logic        arp_wr_en;
  logic [7:0]  arp_wr_addr;
  logic [47:0] arp_wr_data;
  logic        app_tx_valid;
  logic        app_tx_end_of_frame;
  logic [63:0] app_tx_data;
  logic [31:0] app_tx_dest_ip;
  logic [15:0] app_tx_dest_port;
  logic        mac_tx_ack;
  logic        app_tx_afull;
  logic        app_tx_overflow;
  logic [63:0] mac_tx_data;
  logic [7:0]  mac_tx_data_valid;
  logic        mac_tx_start;

  `include "tb_frame_model.svh"

  // Ack -1 picks a random delay
  frame_row_t rows [NROWS] = '{
    '{4, 32'hC0A80A21, 16'h1234, 1'b1, 0},
    '{3, 32'h08080808, 16'h0035, 1'b1, 1},
    '{1, 32'hC0A80A07, 16'h4000, 1'b1, 0},
    '{2, 32'hC0A80AFE, 16'h4001, 1'b1, 0},
    '{9, 32'hC0A80A07, 16'h4002, 1'b1, 2},
    '{5, 32'hC0A80A30, 16'h5000, 1'b0, 0},
    '{2, 32'h0A000001, 16'h5001, 1'b0, -1},
    '{6, 32'hC0A80A31, 16'h5002, 1'b1, -1},
    '{3, 32'hC0A80A90, 16'h5003, 1'b1, -1}
  };

  int          exp_words_q [$];
  int          ack_dly_q [$];
  int          frames_queued = 0;
  int          frames_started = 0;
  int          frames_done = 0;
  int          cur_words = 0;
  int          word_cnt = 0;
  logic        in_frame = 1'b0;
  logic        first_pending = 1'b0;
  logic        held_seen = 1'b0;
  logic [63:0] held_word;
  int          cycles = 0;
  int          cycle_limit = 100000;

  udp_tx_top #(
    .DATA_DEPTH   (1024),
    .CTRL_DEPTH   (CTRL_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) dut (
    .mac_clk             (mac_clk),
    .app_rst             (app_rst),
    .local_enable        (local_enable),
    .local_mac           (local_mac),
    .local_ip            (local_ip),
    .local_port          (local_port),
    .local_gateway       (local_gateway),
    .arp_wr_en           (arp_wr_en),
    .arp_wr_addr         (arp_wr_addr),
    .arp_wr_data         (arp_wr_data),
    .app_tx_valid        (app_tx_valid),
    .app_tx_end_of_frame (app_tx_end_of_frame),
    .app_tx_data         (app_tx_data),
    .app_tx_dest_ip      (app_tx_dest_ip),
    .app_tx_dest_port    (app_tx_dest_port),
    .app_tx_afull        (app_tx_afull),
    .app_tx_overflow     (app_tx_overflow),
    .mac_tx_data         (mac_tx_data),
    .mac_tx_data_valid   (mac_tx_data_valid),
    .mac_tx_start        (mac_tx_start),
    .mac_tx_ack          (mac_tx_ack)
  );

  always #20 mac_clk = ~mac_clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge mac_clk);
    #2;
  endtask

  // Called 2 ns after an edge and returns at the same phase
  task automatic send_frame(input int nwords, input logic [31:0] dip, input logic [15:0] dport,
                            input int ack_dly, input logic expect_out);
    logic [63:0] w;
    logic [7:0]  idx;
    if (expect_out) begin
      idx = (dip[31:8] != local_ip[31:8]) ? local_gateway : dip[7:0];
      model_header(arp_fill(idx), dip, dport, nwords);
      exp_words_q.push_back(nwords + 6);
      ack_dly_q.push_back((ack_dly < 0) ? int'(lfsr_take(3)) : ack_dly);
    end
    for (int i = 0; i < nwords; i++) begin
      w = lfsr_take(64);
      if (expect_out) begin
        push64(w);
      end
      app_tx_valid        = 1'b1;
      app_tx_data         = w;
      app_tx_end_of_frame = (i == nwords - 1);
      app_tx_dest_ip      = dip;
      app_tx_dest_port    = dport;
      wait_cycles(1);
    end
    app_tx_valid        = 1'b0;
    app_tx_end_of_frame = 1'b0;
    if (expect_out) begin
      frames_queued++;
    end
  endtask

  task automatic check_word();
    logic [7:0] keep_exp;
    logic [7:0] b_exp;
    word_cnt++;
    keep_exp = (word_cnt == cur_words) ? 8'h03 : 8'hFF;
    assert (mac_tx_data_valid == keep_exp) else stop_on_error($sformatf(
      "ERROR t=%0t mac_tx_data_valid word %0d: expected %02h actual %02h",
      $time, word_cnt, keep_exp, mac_tx_data_valid));
    for (int i = 0; i < 8; i++) begin
      if (mac_tx_data_valid[i]) begin
        assert (exp_bytes.size() > 0) else stop_on_error("a byte was sent beyond the model");
        b_exp = exp_bytes.pop_front();
        assert (mac_tx_data[8*i +: 8] == b_exp) else stop_on_error($sformatf(
          "ERROR t=%0t mac_tx_data frame %0d word %0d lane %0d: expected %02h actual %02h",
          $time, frames_started, word_cnt, i, b_exp, mac_tx_data[8*i +: 8]));
      end
    end
    if (word_cnt == cur_words) begin
      in_frame = 1'b0;
      frames_done++;
    end
  endtask

  // Monitor samples mid-cycle
  always @(negedge mac_clk) begin
    if (!app_rst) begin
      if (mac_tx_start) begin
        assert (!in_frame) else stop_on_error("new frame started before the last one ended");
        assert (frames_started < frames_queued) else
          stop_on_error("a frame started while none was expected");
        frames_started++;
        cur_words     = exp_words_q.pop_front();
        word_cnt      = 0;
        in_frame      = 1'b1;
        first_pending = 1'b1;
        held_seen     = 1'b0;
      end else if (mac_tx_data_valid != 8'h00) begin
        assert (in_frame) else stop_on_error("byte valid seen outside a frame");
        if (first_pending && held_seen) begin
          assert (mac_tx_data == held_word) else stop_on_error($sformatf(
            "ERROR t=%0t mac_tx_data held first word: expected %016h actual %016h",
            $time, held_word, mac_tx_data));
        end
        if (first_pending && !mac_tx_ack) begin
          held_word = mac_tx_data;
          held_seen = 1'b1;
        end else begin
          first_pending = 1'b0;
          check_word();
        end
      end
    end
  end

  // MAC side acks the first word after the frame's delay
  always begin
    int dly;
    @(negedge mac_clk);
    if (!app_rst && mac_tx_start) begin
      dly = (ack_dly_q.size() > 0) ? ack_dly_q.pop_front() : 0;
      @(posedge mac_clk);
      repeat (dly) @(posedge mac_clk);
      #2;
      mac_tx_ack = 1'b1;
      wait_cycles(1);
      mac_tx_ack = 1'b0;
    end
  end

  always @(posedge mac_clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      stop_on_error($sformatf("timeout: run still busy after %0d cycles", cycles));
    end
  end

  initial begin
    int starts_before;
    int afull_at;
    int ovf_at;
    app_rst             = 1'b1;
    local_enable        = 1'b0;
    local_mac           = 48'h000A35010203;
    local_ip            = 32'hC0A80A05;
    local_port          = 16'h1F90;
    local_gateway       = 8'h01;
    arp_wr_en           = 1'b0;
    arp_wr_addr         = '0;
    arp_wr_data         = '0;
    app_tx_valid        = 1'b0;
    app_tx_end_of_frame = 1'b0;
    app_tx_data         = '0;
    app_tx_dest_ip      = '0;
    app_tx_dest_port    = '0;
    mac_tx_ack          = 1'b0;

    // Budget for table words, ack delays, ARP fill and the overflow phase
    cycle_limit = 256 + 120 + 2 * (CTRL_DEPTH + 6) + 60;
    foreach (rows[i]) begin
      cycle_limit += 2 * rows[i].nwords + 40;
    end

    repeat (4) @(posedge mac_clk);
    #2;
    app_rst = 1'b0;
    assert (!mac_tx_start && mac_tx_data_valid == 8'h00 && !app_tx_overflow &&
            !app_tx_afull) else
      stop_on_error("outputs not idle after reset");

    for (int a = 0; a < 256; a++) begin
      arp_wr_en   = 1'b1;
      arp_wr_addr = 8'(a);
      arp_wr_data = arp_fill(8'(a));
      wait_cycles(1);
    end
    arp_wr_en = 1'b0;

    foreach (rows[i]) begin
      local_enable  = rows[i].en;
      starts_before = frames_started;
      send_frame(rows[i].nwords, rows[i].dip, rows[i].dport, rows[i].ack, 1'b1);
      if (!rows[i].en) begin
        wait_cycles(12);
        assert (frames_started == starts_before) else
          stop_on_error("a frame started while local_enable was low");
      end
    end

    local_enable = 1'b1;
    wait (frames_done == frames_queued);
    wait_cycles(4);
    assert (exp_bytes.size() == 0) else stop_on_error("expected bytes were never sent");

    // Fill the descriptor FIFO past full with sending held off
    local_enable = 1'b0;
    afull_at     = -1;
    ovf_at       = -1;
    for (int k = 0; k < CTRL_DEPTH + 6; k++) begin
      send_frame(1, 32'hC0A80A44, 16'h6000, 0, 1'b0);
      if (app_tx_afull && afull_at < 0) begin
        afull_at = k;
      end
      if (app_tx_overflow && ovf_at < 0) begin
        ovf_at = k;
      end
    end
    wait_cycles(3);
    assert (app_tx_overflow) else stop_on_error("overflow flag did not rise");
    // Almost-full rises once AFULL_MARGIN entries are left free
    assert (afull_at == CTRL_DEPTH - AFULL_MARGIN - 1) else stop_on_error($sformatf(
      "ERROR t=%0t app_tx_afull first descriptor index: expected %0d actual %0d",
      $time, CTRL_DEPTH - AFULL_MARGIN - 1, afull_at));
    assert (ovf_at < 0 || ovf_at >= CTRL_DEPTH) else
      stop_on_error("overflow flag rose before the descriptor FIFO was full");

    starts_before = frames_started;
    local_enable  = 1'b1;
    wait_cycles(20);
    assert (frames_started == starts_before && !mac_tx_start) else
      stop_on_error("a frame started after overflow");

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+dv
hw/net_hdr_pkg.sv
hw/tx_path_pkg.sv
hw/frame_desc_if.sv
hw/sync_fifo.sv
hw/tx_frame_queue.sv
hw/arp_table.sv
hw/udp_hdr_calc.sv
hw/udp_tx_framer.sv
hw/udp_tx_top.sv
dv/tb_udp_tx.sv

/* Makefile */
TOP := tb_udp_tx

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): project.f hw/*.sv dv/*.sv dv/*.svh
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

lint:
	verilator --lint-only -Wall --timing --top-module udp_tx_top -f project.f

clean:
	rm -rf obj_dir
